// File: flist.f
+incdir+include
rtl/png_pixel_pkg.sv
rtl/png_ctrl_pkg.sv
rtl/png_filter_ifs.sv
rtl/png_filter_ctrl.sv
rtl/png_nbr_fetch.sv
rtl/png_chan_pred.sv
rtl/png_cost_select.sv
rtl/png_filter_top.sv
verification/png_filter_sva.sv
verification/png_filter_tb.sv

// File: verification/png_filter_tb.sv
/* testbench for the scanline filter engine: clock, reset, FIFO models, image patterns,
   reference filter model, checks, per-test reports and watchdog */

`timescale 1ns/1ps

`include "png_filter_config.svh"

module png_filter_tb;

  localparam int NUM_TESTS = 6;
  localparam int NUM_FLT   = 5;
  localparam int MAX_W     = 16;
  localparam int MAX_H     = 4;
  localparam int PERIOD    = 40;
  localparam int DRIVE_DLY = 2;
  localparam int HDR_POS   = 24;

  logic                      clk = 1'b0;
  logic                      rstn;
  logic [`PNG_SIZE_W_WD-1:0] cfg_w_i;
  logic [`PNG_SIZE_H_WD-1:0] cfg_h_i;
  logic                      start_i;
  logic                      val_i;
  logic [`PNG_PXL_WD-1:0]    dat_i;
  logic                      done_o;
  logic [`PNG_SIZE_H_WD-1:0] cnt_h_o;
  logic                      fifo_cur_wr_val_o;
  logic [`PNG_PXL_WD-1:0]    fifo_cur_wr_dat_o;
  logic                      fifo_cur_rd_val_o;
  logic [`PNG_PXL_WD-1:0]    fifo_cur_rd_dat_i;
  logic                      fifo_flt_wr_val_o;
  logic [`PNG_PXL_WD-1:0]    fifo_flt_wr_dat_o;
  logic                      fifo_pre_rd_val_o;
  logic [`PNG_PXL_WD-1:0]    fifo_pre_rd_dat_i;

  logic [`PNG_PXL_WD-1:0] img [MAX_H][MAX_W];
  logic [`PNG_PXL_WD-1:0] exp_res [NUM_FLT][MAX_W];
  logic [`PNG_PXL_WD-1:0] cur_q [$];
  logic [`PNG_PXL_WD-1:0] pre_q [$];
  logic [`PNG_PXL_WD-1:0] flt_q [$];
  logic [`PNG_PXL_WD-1:0] prev_dat;
  logic [`PNG_PXL_WD-1:0] cur_next;
  logic [`PNG_PXL_WD-1:0] pre_next;
  logic                   prev_val;
  logic                   cur_load;
  logic                   pre_load;
  int                     cur_row;
  int                     done_cnt;
  int                     rows_done;
  int                     errors;
  int                     tests_failed;
  string                  test_name;

  png_filter_top DUT (.*);

  always #(PERIOD / 2) clk = ~clk;

  // --------------------
  // test table
  // --------------------
  function automatic int width_of(input int t);
    case (t)
      0: return 12;
      1: return 10;
      2: return 8;
      3: return 9;
      4: return 12;
      default: return 7;
    endcase
  endfunction

  function automatic int height_of(input int t);
    case (t)
      0: return 3;
      1: return 2;
      default: return 4;
    endcase
  endfunction

  function automatic string name_of(input int t);
    case (t)
      0: return "random";
      1: return "checker";
      2: return "constant";
      3: return "repeat";
      4: return "ramp";
      default: return "gradient";
    endcase
  endfunction

  // neighbours outside the image read as zero
  function automatic int chan_at(input int j, input int i, input int k);
    if (i < 0 || j < 0) begin
      return 0;
    end
    return int'(img[j][i][8*k +: 8]);
  endfunction

  function automatic int abs_int(input int v);
    return (v < 0) ? -v : v;
  endfunction

  task automatic report_value(input string what, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    $display("FAIL %s %s expected %h actual %h", test_name, what, exp_v, act_v);
    errors++;
  endtask

  task automatic report_fault(input string msg);
    $display("ERROR %s: %s", test_name, msg);
    errors++;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DLY);
  endtask

  // --------------------
  // image patterns and reference model
  // --------------------
  task automatic build_image(input int t, input int w, input int h);
    int v;
    for (int j = 0; j < h; j++) begin
      for (int i = 0; i < w; i++) begin
        for (int k = 0; k < `PNG_CHN_NUM; k++) begin
          case (t)
            0: v = $urandom_range(255);
            // checkerboard favours none
            1: v = ((i + j) % 2 == 1) ? 100 : 0;
            2: v = 90 + 7 * k;
            // first row repeated down the image
            3: v = (j == 0) ? $urandom_range(255) : chan_at(0, i, k);
            // odd rows are the exact average of left and up
            4: v = (j % 2 == 1) ? (chan_at(j, i - 1, k) + chan_at(j - 1, i, k)) / 2
                                : 200 - 4 * k;
            default: v = 40 + 30 * j + 2 * k;
          endcase
          img[j][i][8*k +: 8] = v[7:0];
        end
      end
    end
  endtask

  task automatic model_row(input int j, input int w, output int best);
    int cost [NUM_FLT];
    int r [NUM_FLT];
    int x;
    int a;
    int b;
    int c;
    int p;
    int pa;
    int pb;
    int pc;
    int pr;
    for (int t = 0; t < NUM_FLT; t++) cost[t] = 0;
    for (int i = 0; i < w; i++) begin
      for (int k = 0; k < `PNG_CHN_NUM; k++) begin
        x  = chan_at(j, i, k);
        a  = chan_at(j, i - 1, k);
        b  = chan_at(j - 1, i, k);
        c  = chan_at(j - 1, i - 1, k);
        p  = a + b - c;
        pa = abs_int(p - a);
        pb = abs_int(p - b);
        pc = abs_int(p - c);
        if (pa <= pb && pa <= pc) begin
          pr = a;
        end else if (pb <= pc) begin
          pr = b;
        end else begin
          pr = c;
        end
        r[0] = x;
        r[1] = (x - a) & 255;
        r[2] = (x - b) & 255;
        r[3] = (x - (a + b) / 2) & 255;
        r[4] = (x - pr) & 255;
        cost[0] += r[0];
        for (int t = 1; t < NUM_FLT; t++) begin
          cost[t] += (r[t] < 128) ? r[t] : 255 - r[t];
        end
        for (int t = 0; t < NUM_FLT; t++) exp_res[t][i][8*k +: 8] = r[t][7:0];
      end
    end
    // first minimum wins
    best = 0;
    for (int t = 1; t < NUM_FLT; t++) begin
      if (cost[t] < cost[best]) begin
        best = t;
      end
    end
  endtask

  // --------------------
  // FIFO models, sampled mid-cycle
  // --------------------
  always begin
    @(negedge clk);
    cur_load = 1'b0;
    pre_load = 1'b0;
    assert (fifo_cur_wr_val_o == prev_val)
      else report_fault("current-line FIFO write strobe does not follow val_i");
    if (fifo_cur_wr_val_o) begin
      assert (fifo_cur_wr_dat_o == prev_dat)
        else report_value("current-line write", prev_dat, fifo_cur_wr_dat_o);
      cur_q.push_back(fifo_cur_wr_dat_o);
    end
    if (fifo_cur_rd_val_o) begin
      if (cur_q.size() == 0) begin
        report_fault("current-line FIFO read while empty");
      end else begin
        cur_next = cur_q.pop_front();
        cur_load = 1'b1;
      end
    end
    if (fifo_pre_rd_val_o) begin
      assert (cur_row != 0) else report_fault("previous-line FIFO read in row 0");
      if (pre_q.size() == 0) begin
        report_fault("previous-line FIFO read while empty");
      end else begin
        pre_next = pre_q.pop_front();
        pre_load = 1'b1;
      end
    end
    if (fifo_flt_wr_val_o) begin
      flt_q.push_back(fifo_flt_wr_dat_o);
    end
    if (done_o) begin
      done_cnt++;
    end
    prev_val = val_i;
    prev_dat = dat_i;
    // one cycle read latency
    next_cycle();
    if (cur_load) begin
      fifo_cur_rd_dat_i = cur_next;
    end
    if (pre_load) begin
      fifo_pre_rd_dat_i = pre_next;
    end
  end

  // --------------------
  // row and test sequencing
  // --------------------
  task automatic send_row(input int j, input int w);
    for (int i = 0; i < w; i++) begin
      if ($urandom_range(3) == 0) begin
        val_i = 1'b0;
        dat_i = $urandom;
        next_cycle();
      end
      val_i = 1'b1;
      dat_i = img[j][i];
      next_cycle();
    end
    val_i = 1'b0;
  endtask

  task automatic run_row(input int j, input int w, output int best);
    int base;
    model_row(j, w, best);
    assert (cnt_h_o == j) else report_value($sformatf("row counter at row %0d", j), j, cnt_h_o);
    // previous row is read once in each pass
    if (j > 0) begin
      for (int n = 0; n < 2; n++) begin
        for (int i = 0; i < w; i++) pre_q.push_back(img[j - 1][i]);
      end
    end
    cur_row = j;
    base    = done_cnt;
    start_i = 1'b1;
    next_cycle();
    start_i = 1'b0;
    send_row(j, w);
    while (done_cnt == base) begin
      @(posedge clk);
    end
    #(DRIVE_DLY);
    rows_done++;
    assert (flt_q.size() == w + 1)
      else report_fault($sformatf("row %0d wrote %0d filtered words instead of %0d",
                                  j, flt_q.size(), w + 1));
    if (flt_q.size() > 0) begin
      assert (flt_q[0] == (32'(best) << HDR_POS))
        else report_value($sformatf("row %0d header", j), 32'(best) << HDR_POS, flt_q[0]);
    end
    for (int i = 1; i < flt_q.size() && i <= w; i++) begin
      assert (flt_q[i] == exp_res[best][i - 1])
        else report_value($sformatf("row %0d residual %0d", j, i - 1),
                          exp_res[best][i - 1], flt_q[i]);
    end
    flt_q.delete();
    // nothing may follow the done pulse
    next_cycle();
    assert (flt_q.size() == 0 && cur_q.size() == 0 && pre_q.size() == 0)
      else report_fault($sformatf("FIFO words left over after row %0d", j));
    assert (done_cnt == rows_done)
      else report_fault($sformatf("done_o pulsed more than once in row %0d", j));
  endtask

  task automatic run_test(input int t);
    int    w;
    int    h;
    int    err0;
    int    best;
    string types;
    w         = width_of(t);
    h         = height_of(t);
    test_name = name_of(t);
    err0      = errors;
    types     = "";
    cfg_w_i   = w[`PNG_SIZE_W_WD-1:0];
    cfg_h_i   = h[`PNG_SIZE_H_WD-1:0];
    build_image(t, w, h);
    next_cycle();
    for (int j = 0; j < h; j++) begin
      run_row(j, w, best);
      types = {types, $sformatf(" %0d", best)};
    end
    assert (cnt_h_o == 0) else report_value("row counter after last row", 0, cnt_h_o);
    if (errors != err0) begin
      tests_failed++;
    end
    $display("%-9s %0dx%0d types%s : %s", test_name, w, h, types,
             (errors == err0) ? "ok" : "failed");
  endtask

  initial begin
    void'($urandom(58497));
    rstn              = 1'b0;
    cfg_w_i           = '0;
    cfg_h_i           = '0;
    start_i           = 1'b0;
    val_i             = 1'b0;
    dat_i             = '0;
    fifo_cur_rd_dat_i = '0;
    fifo_pre_rd_dat_i = '0;
    prev_val          = 1'b0;
    prev_dat          = '0;
    cur_row           = 0;
    done_cnt          = 0;
    rows_done         = 0;
    errors            = 0;
    tests_failed      = 0;
    test_name         = "reset";
    repeat (5) @(posedge clk);
    #(DRIVE_DLY);
    rstn = 1'b1;
    next_cycle();
    for (int t = 0; t < NUM_TESTS; t++) run_test(t);
    $display("tests %0d, failed %0d, check errors %0d, assertion errors %0d",
             NUM_TESTS, tests_failed, errors, DUT.u_sva.fail_cnt);
    if (errors == 0 && DUT.u_sva.fail_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // three passes of about width + 12 cycles per row
  initial begin : watchdog
    int budget;
    budget = 100;
    for (int t = 0; t < NUM_TESTS; t++) begin
      budget += 3 * (width_of(t) + 12) * height_of(t) + 10;
    end
    #(budget * PERIOD);
    $display("watchdog expired after %0d cycles, the DUT stopped finishing rows", budget);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: verification/png_filter_sva.sv
/* protocol assertions on the filter top level, attached by bind */

`timescale 1ns/1ps

`include "png_filter_config.svh"

module png_filter_sva (
  input logic                      clk,
  input logic                      rstn,
  input logic                      start_i,
  input logic                      val_i,
  input logic [`PNG_PXL_WD-1:0]    dat_i,
  input logic                      done_o,
  input logic [`PNG_SIZE_H_WD-1:0] cnt_h_o,
  input logic                      fifo_cur_wr_val_o,
  input logic [`PNG_PXL_WD-1:0]    fifo_cur_wr_dat_o,
  input logic                      fifo_cur_rd_val_o,
  input logic                      fifo_flt_wr_val_o,
  input logic                      fifo_pre_rd_val_o
);

  int   fail_cnt = 0;
  logic started;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      started <= 1'b0;
    end else if (start_i) begin
      started <= 1'b1;
    end
  end

  // --------------------
  // strobe rules
  // --------------------
  // quiet in reset and until the first start
  a_quiet: assert property (@(posedge clk)
    !started |-> !(fifo_cur_wr_val_o || fifo_cur_rd_val_o || fifo_flt_wr_val_o ||
                   fifo_pre_rd_val_o || done_o))
    else begin
      fail_cnt++;
      $error("strobe or done active before the first start");
    end

  a_cur_copy: assert property (@(posedge clk) disable iff (!rstn)
    val_i |=> fifo_cur_wr_val_o && (fifo_cur_wr_dat_o == $past(dat_i)))
    else begin
      fail_cnt++;
      $error("current-line write does not copy the previous input");
    end

  a_cur_idle: assert property (@(posedge clk) disable iff (!rstn)
    !val_i |=> !fifo_cur_wr_val_o)
    else begin
      fail_cnt++;
      $error("current-line write without an input pixel");
    end

  a_pre_row0: assert property (@(posedge clk) disable iff (!rstn)
    fifo_pre_rd_val_o |-> (cnt_h_o != '0))
    else begin
      fail_cnt++;
      $error("previous-line read in row 0");
    end

  // done is a single pulse on the last residual write
  a_done_pulse: assert property (@(posedge clk) disable iff (!rstn)
    done_o |=> !done_o)
    else begin
      fail_cnt++;
      $error("done held for more than one cycle");
    end

  a_done_write: assert property (@(posedge clk) disable iff (!rstn)
    done_o |-> fifo_flt_wr_val_o)
    else begin
      fail_cnt++;
      $error("done without the last filtered write");
    end

endmodule

bind png_filter_top png_filter_sva u_sva (.*);

// File: rtl/png_filter_top.sv
/* scanline filter top: sequencer, neighbour fetch, channel lanes
   and cost selector */

`timescale 1ns/1ps

`include "png_filter_config.svh"

module png_filter_top (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic [`PNG_SIZE_W_WD-1:0] cfg_w_i,
  input  logic [`PNG_SIZE_H_WD-1:0] cfg_h_i,
  input  logic                      start_i,
  input  logic                      val_i,
  input  logic [`PNG_PXL_WD-1:0]    dat_i,
  output logic                      done_o,
  output logic [`PNG_SIZE_H_WD-1:0] cnt_h_o,
  // current line FIFO
  output logic                      fifo_cur_wr_val_o,
  output logic [`PNG_PXL_WD-1:0]    fifo_cur_wr_dat_o,
  output logic                      fifo_cur_rd_val_o,
  input  logic [`PNG_PXL_WD-1:0]    fifo_cur_rd_dat_i,
  // filtered FIFO
  output logic                      fifo_flt_wr_val_o,
  output logic [`PNG_PXL_WD-1:0]    fifo_flt_wr_dat_o,
  // previous line FIFO
  output logic                      fifo_pre_rd_val_o,
  input  logic [`PNG_PXL_WD-1:0]    fifo_pre_rd_dat_i
);

  png_step_if step_if ();
  png_nbr_if  nbr_if ();
  png_res_if  res_if ();

  png_filter_ctrl u_ctrl (
    .clk               (clk),
    .rstn              (rstn),
    .cfg_w_i           (cfg_w_i),
    .cfg_h_i           (cfg_h_i),
    .start_i           (start_i),
    .val_i             (val_i),
    .done_o            (done_o),
    .cnt_h_o           (cnt_h_o),
    .fifo_cur_rd_val_o (fifo_cur_rd_val_o),
    .fifo_pre_rd_val_o (fifo_pre_rd_val_o),
    .step              (step_if)
  );

  png_nbr_fetch u_fetch (
    .clk               (clk),
    .rstn              (rstn),
    .val_i             (val_i),
    .dat_i             (dat_i),
    .fifo_cur_rd_dat_i (fifo_cur_rd_dat_i),
    .fifo_pre_rd_dat_i (fifo_pre_rd_dat_i),
    .fifo_cur_wr_val_o (fifo_cur_wr_val_o),
    .fifo_cur_wr_dat_o (fifo_cur_wr_dat_o),
    .step              (step_if),
    .nbr               (nbr_if)
  );

  // one predictor per channel
  for (genvar k = 0; k < `PNG_CHN_NUM; k++) begin : g_lane
    png_chan_pred #(.LANE(k)) u_pred (
      .clk  (clk),
      .rstn (rstn),
      .nbr  (nbr_if),
      .res  (res_if)
    );
  end

  png_cost_select u_cost (
    .clk               (clk),
    .rstn              (rstn),
    .res               (res_if),
    .step              (step_if),
    .fifo_flt_wr_val_o (fifo_flt_wr_val_o),
    .fifo_flt_wr_dat_o (fifo_flt_wr_dat_o)
  );

endmodule

// File: rtl/png_cost_select.sv
/* per-row cost accumulators, cheapest-filter search and
   filtered FIFO write mux */

`timescale 1ns/1ps

`include "png_filter_config.svh"

module png_cost_select (
  input  logic                  clk,
  input  logic                  rstn,
  png_res_if.cost               res,
  png_step_if.cost              step,
  output logic                  fifo_flt_wr_val_o,
  output png_pixel_pkg::pixel_u fifo_flt_wr_dat_o
);
  import png_pixel_pkg::*;

  // type field sits in the top byte of the header word
  localparam int HDR_LSB = `PNG_PXL_WD - `PNG_CHN_WD;

  cost_t     acc_r [FLT_NUM];
  flt_type_e best_type_r;
  cost_t     best_cost_r;
  flt_type_e cand_type;
  cost_t     cand_cost;
  flt_type_e inc_type;
  cost_t     inc_cost;
  logic      wr_val_r;
  pixel_u    wr_dat_r;
  pixel_u    wr_dat_w;

  function automatic cost_t pix_cost(input pixel_u p);
    cost_t s;
    s = '0;
    for (int k = 0; k < `PNG_CHN_NUM; k++) s += cost_t'(p.chan[k]);
    return s;
  endfunction

  // --------------------
  // cost accumulation
  // --------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < FLT_NUM; i++) acc_r[i] <= '0;
    end else if (step.acc_en) begin
      for (int i = 0; i < FLT_NUM; i++) begin
        acc_r[i] <= (step.acc_first ? cost_t'(0) : acc_r[i]) + pix_cost(res.mag[i]);
      end
    end
  end

  // --------------------
  // minimum search
  // --------------------
  always_comb begin
    case (step.cmp_idx)
      3'd0:    cand_type = FLT_SUB;
      3'd1:    cand_type = FLT_UP;
      3'd2:    cand_type = FLT_AVG;
      default: cand_type = FLT_PAETH;
    endcase
    cand_cost = acc_r[cand_type];
    // step 0 starts from none
    inc_type  = (step.cmp_idx == '0) ? FLT_NONE : best_type_r;
    inc_cost  = (step.cmp_idx == '0) ? acc_r[FLT_NONE] : best_cost_r;
  end

  // strictly lower wins, so ties keep the lower type
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      best_type_r <= FLT_NONE;
      best_cost_r <= '0;
    end else if (step.cmp_en && (step.cmp_idx != 3'(`PNG_CMP_CYC - 1))) begin
      if (cand_cost < inc_cost) begin
        best_type_r <= cand_type;
        best_cost_r <= cand_cost;
      end else begin
        best_type_r <= inc_type;
        best_cost_r <= inc_cost;
      end
    end
  end

  // --------------------
  // filtered FIFO write
  // --------------------
  always_comb begin
    wr_dat_w.raw = '0;
    if (step.hdr_we) begin
      wr_dat_w.raw[HDR_LSB +: $bits(flt_type_e)] = best_type_r;
    end else begin
      wr_dat_w = res.res[best_type_r];
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_val_r <= 1'b0;
    end else begin
      wr_val_r <= step.hdr_we || step.res_we;
    end
  end

  always_ff @(posedge clk) begin
    wr_dat_r <= wr_dat_w;
  end

  assign fifo_flt_wr_val_o = wr_val_r;
  assign fifo_flt_wr_dat_o = wr_dat_r;

endmodule

// File: rtl/png_chan_pred.sv
/* one channel lane: five predictions, paeth choice, residual registers
   and magnitudes */

`timescale 1ns/1ps

module png_chan_pred #(
  parameter int LANE = 0
) (
  input  logic    clk,
  input  logic    rstn,
  png_nbr_if.lane nbr,
  png_res_if.lane res
);
  import png_pixel_pkg::*;

  chan_t             x;
  chan_t             a;
  chan_t             b;
  chan_t             c;
  logic [8:0]        ab_sum;
  logic signed [9:0] pa;
  logic signed [9:0] pb;
  logic signed [9:0] pc;
  chan_t             pth;
  chan_t             res_w [FLT_NUM];
  chan_t             res_r [FLT_NUM];

  function automatic logic signed [9:0] abs10(input logic signed [9:0] v);
    return (v < 0) ? -v : v;
  endfunction

  assign x = nbr.x.chan[LANE];
  assign a = nbr.a.chan[LANE];
  assign b = nbr.b.chan[LANE];
  assign c = nbr.c.chan[LANE];

  // paeth distances to p = a + b - c
  assign pa = abs10($signed({2'b00, b}) - $signed({2'b00, c}));
  assign pb = abs10($signed({2'b00, a}) - $signed({2'b00, c}));
  assign pc = abs10($signed({2'b00, a}) + $signed({2'b00, b}) - $signed({1'b0, c, 1'b0}));
  assign pth = ((pa <= pb) && (pa <= pc)) ? a : ((pb <= pc) ? b : c);

  assign ab_sum = {1'b0, a} + {1'b0, b};

  // residuals wrap modulo 256
  assign res_w[FLT_NONE]  = x;
  assign res_w[FLT_SUB]   = x - a;
  assign res_w[FLT_UP]    = x - b;
  assign res_w[FLT_AVG]   = x - ab_sum[8:1];
  assign res_w[FLT_PAETH] = x - pth;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < FLT_NUM; i++) res_r[i] <= '0;
    end else begin
      for (int i = 0; i < FLT_NUM; i++) res_r[i] <= res_w[i];
    end
  end

  // none counts its raw value, others fold around 128
  for (genvar i = 0; i < FLT_NUM; i++) begin : g_flt
    assign res.res[i].chan[LANE] = res_r[i];
    assign res.mag[i].chan[LANE] = (i == 0 || res_r[i] < chan_t'(128)) ?
                                   res_r[i] : chan_t'(255) - res_r[i];
  end

endmodule

// File: rtl/png_nbr_fetch.sv
/* input delay, current-line FIFO write and x/a/b/c neighbour selection */

`timescale 1ns/1ps

module png_nbr_fetch (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  val_i,
  input  png_pixel_pkg::pixel_u dat_i,
  input  png_pixel_pkg::pixel_u fifo_cur_rd_dat_i,
  input  png_pixel_pkg::pixel_u fifo_pre_rd_dat_i,
  output logic                  fifo_cur_wr_val_o,
  output png_pixel_pkg::pixel_u fifo_cur_wr_dat_o,
  png_step_if.fetch             step,
  png_nbr_if.src                nbr
);
  import png_pixel_pkg::*;

  logic   wr_val_r;
  pixel_u dat_d1;
  pixel_u x_w;
  pixel_u a_r;
  pixel_u c_r;

  // input delay line, doubles as the current-line write register
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_val_r <= 1'b0;
    end else begin
      wr_val_r <= val_i;
    end
  end

  always_ff @(posedge clk) begin
    dat_d1 <= dat_i;
  end

  assign fifo_cur_wr_val_o = wr_val_r;
  assign fifo_cur_wr_dat_o = dat_d1;

  // --------------------
  // neighbour window
  // --------------------
  //  c b
  //  a x
  assign x_w = step.opt_path ? dat_d1 : fifo_cur_rd_dat_i;

  // this pixel becomes the next one's left, its up becomes up-left
  always_ff @(posedge clk) begin
    if (step.load_en) begin
      a_r <= x_w;
      c_r <= fifo_pre_rd_dat_i;
    end
  end

  // zero neighbours outside the image
  assign nbr.x = x_w;
  assign nbr.a = step.col_first ? '0 : a_r;
  assign nbr.b = step.row_first ? '0 : fifo_pre_rd_dat_i;
  assign nbr.c = (step.col_first || step.row_first) ? '0 : c_r;

endmodule

// File: rtl/png_filter_ctrl.sv
/* pass sequencer: FSM, column/row/compare counters, stage flags,
   FIFO read strobes and row done */

`timescale 1ns/1ps

`include "png_filter_config.svh"

module png_filter_ctrl (
  input  logic               clk,
  input  logic               rstn,
  input  png_ctrl_pkg::col_t cfg_w_i,
  input  png_ctrl_pkg::row_t cfg_h_i,
  input  logic               start_i,
  input  logic               val_i,
  output logic               done_o,
  output png_ctrl_pkg::row_t cnt_h_o,
  output logic               fifo_cur_rd_val_o,
  output logic               fifo_pre_rd_val_o,
  png_step_if.ctrl           step
);
  import png_ctrl_pkg::*;

  pass_e    state_r;
  pass_e    state_nxt;
  col_t     col_r;
  col_t     col_d1;
  col_t     col_d2;
  row_t     row_r;
  cmp_idx_t cmp_r;
  logic     busy_w;
  logic     busy_d1;
  logic     busy_d2;
  logic     col_done_w;
  logic     col_done_d1;
  logic     col_done_d2;
  logic     col_done_d3;
  logic     cmp_done;
  logic     fnl_done;

  // --------------------
  // pass FSM
  // --------------------
  assign cmp_done = (state_r == CMP) && (cmp_r == cmp_idx_t'(`PNG_CMP_CYC - 1));
  assign fnl_done = (state_r == FNL) && col_done_d3;

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      IDLE:    if (start_i) state_nxt = OPT;
      OPT:     if (col_done_d3) state_nxt = CMP;
      CMP:     if (cmp_done) state_nxt = FNL;
      FNL:     if (fnl_done) state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_r <= IDLE;
    end else begin
      state_r <= state_nxt;
    end
  end

  // opt takes every valid pixel, fnl reads exactly one row
  assign busy_w = ((state_r == OPT) && val_i) ||
                  ((state_r == FNL) && !(col_done_d1 || col_done_d2 || col_done_d3));
  assign col_done_w = busy_w && (col_r == cfg_w_i - col_t'(1));

  // --------------------
  // counters
  // --------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      col_r <= '0;
      row_r <= '0;
      cmp_r <= '0;
    end else begin
      if (busy_w) begin
        col_r <= col_done_w ? '0 : col_r + col_t'(1);
      end
      if (fnl_done) begin
        row_r <= (row_r == cfg_h_i - row_t'(1)) ? '0 : row_r + row_t'(1);
      end
      if (state_r == CMP) begin
        cmp_r <= cmp_done ? '0 : cmp_r + cmp_idx_t'(1);
      end
    end
  end

  // stage flags follow each pixel down the pipeline
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy_d1     <= 1'b0;
      busy_d2     <= 1'b0;
      col_d1      <= '0;
      col_d2      <= '0;
      col_done_d1 <= 1'b0;
      col_done_d2 <= 1'b0;
      col_done_d3 <= 1'b0;
    end else begin
      busy_d1     <= busy_w;
      busy_d2     <= busy_d1;
      col_d1      <= col_r;
      col_d2      <= col_d1;
      col_done_d1 <= col_done_w;
      col_done_d2 <= col_done_d1;
      col_done_d3 <= col_done_d2;
    end
  end

  // --------------------
  // outputs
  // --------------------
  assign fifo_cur_rd_val_o = busy_w && (state_r == FNL);
  assign fifo_pre_rd_val_o = busy_w && (row_r != '0);
  assign done_o            = fnl_done;
  assign cnt_h_o           = row_r;

  assign step.load_en   = busy_d1;
  assign step.opt_path  = busy_d1 && (state_r == OPT);
  assign step.col_first = (col_d1 == '0);
  assign step.row_first = (row_r == '0);
  assign step.acc_en    = busy_d2 && (state_r == OPT);
  assign step.acc_first = (col_d2 == '0);
  assign step.cmp_en    = (state_r == CMP);
  assign step.cmp_idx   = cmp_r;
  assign step.hdr_we    = cmp_done;
  assign step.res_we    = busy_d2 && (state_r == FNL);

endmodule

// File: rtl/png_filter_ifs.sv
/* neighbour, residual and step-control interfaces */

`timescale 1ns/1ps

// x/a/b/c window, lane k uses channel k
interface png_nbr_if;
  import png_pixel_pkg::*;

  pixel_u x;
  pixel_u a;
  pixel_u b;
  pixel_u c;

  modport src  (output x, a, b, c);
  modport lane (input  x, a, b, c);
endinterface

// registered residuals and their magnitudes, one entry per filter
interface png_res_if;
  import png_pixel_pkg::*;

  pixel_u res [FLT_NUM];
  pixel_u mag [FLT_NUM];

  modport lane (output res, mag);
  modport cost (input  res, mag);
endinterface

// pipeline controls from the sequencer
interface png_step_if;
  import png_ctrl_pkg::*;

  logic     load_en;
  logic     opt_path;
  logic     col_first;
  logic     row_first;
  logic     acc_en;
  logic     acc_first;
  logic     cmp_en;
  cmp_idx_t cmp_idx;
  logic     hdr_we;
  logic     res_we;

  modport ctrl  (output load_en, opt_path, col_first, row_first,
                 acc_en, acc_first, cmp_en, cmp_idx, hdr_we, res_we);
  modport fetch (input  load_en, opt_path, col_first, row_first);
  modport cost  (input  acc_en, acc_first, cmp_en, cmp_idx, hdr_we, res_we);
endinterface

// File: rtl/png_ctrl_pkg.sv
/* pass states and counter types of the sequencer */

`include "png_filter_config.svh"

package png_ctrl_pkg;

  // one-hot pass state
  typedef enum logic [3:0] {
    IDLE = 4'b0001,
    OPT  = 4'b0010,
    CMP  = 4'b0100,
    FNL  = 4'b1000
  } pass_e;

  typedef logic [`PNG_SIZE_W_WD-1:0] col_t;
  typedef logic [`PNG_SIZE_H_WD-1:0] row_t;
  typedef logic [2:0]                cmp_idx_t;

endpackage

// File: rtl/png_pixel_pkg.sv
/* pixel and channel types, filter type encoding and cost type */

`include "png_filter_config.svh"

package png_pixel_pkg;

  // one colour channel
  typedef logic [`PNG_CHN_WD-1:0] chan_t;

  // whole word for the FIFOs, per channel for prediction
  typedef union packed {
    logic [`PNG_PXL_WD-1:0]     raw;
    chan_t [`PNG_CHN_NUM-1:0]   chan;
  } pixel_u;

  typedef enum logic [2:0] {
    FLT_NONE  = 3'd0,
    FLT_SUB   = 3'd1,
    FLT_UP    = 3'd2,
    FLT_AVG   = 3'd3,
    FLT_PAETH = 3'd4
  } flt_type_e;

  // number of candidate filters
  localparam int FLT_NUM = 5;

  typedef logic [`PNG_COST_WD-1:0] cost_t;

endpackage

// File: include/png_filter_config.svh
/* size and width macros for the scanline filter engine */

`ifndef PNG_FILTER_CONFIG_SVH
`define PNG_FILTER_CONFIG_SVH

// pixel layout
`define PNG_CHN_WD    8
// only four channels are supported
`define PNG_CHN_NUM   4
`define PNG_PXL_WD    32

// frame size counters
`define PNG_SIZE_W_WD 10
`define PNG_SIZE_H_WD 10

// compare pass length
`define PNG_CMP_CYC   5

// holds 4 x 255 x 1023
`define PNG_COST_WD   22

`endif
